/* common/dbg_defines.svh */
/*
 * debug event path size macros
 * packet length, header size, event size and FLAGS field widths
 */
`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

// largest debug packet in flits, header included
`define DBG_MAX_PKT_LEN 8
// DEST, SRC and FLAGS
`define DBG_NUM_HDR_FLITS 3
// payload flits that fit into one packet
`define DBG_MAX_PAYLOAD_LEN ((`DBG_MAX_PKT_LEN) - (`DBG_NUM_HDR_FLITS))

// trace event limits
`define DBG_MAX_EVENT_WORDS 16
`define DBG_WORD_W 16
`define DBG_NUM_WORDS_W 5
`define DBG_IDX_W 4

// FLAGS word encoding
`define DBG_TYPE_EVENT 2'b10
`define DBG_TYPE_SUB_OVERFLOW 4'd5
`define DBG_MOD_SUB_W 3
`define DBG_FLAGS_RSVD_W 10

`endif

/* common/dbg_pkg.sv */
/*
 * shared types of the debug event path
 * debug link flit, FLAGS word views and the trace event record
 */
`include "dbg_defines.svh"

package dbg_pkg;

   // one flit on a debug link
   typedef struct packed {
      logic                   valid;
      logic                   last;
      logic [`DBG_WORD_W-1:0] data;
   } dii_flit;

   // FLAGS seen by an event packet
   // module sub-type plus continue bit in the upper sub-type field
   typedef struct packed {
      logic [1:0]                   pkt_type;
      logic [`DBG_MOD_SUB_W-1:0]    mod_sub;
      logic                         cont;
      logic [`DBG_FLAGS_RSVD_W-1:0] rsvd;
   } flags_event_t;

   // FLAGS seen by an overflow packet
   // the whole sub-type field is one code
   typedef struct packed {
      logic [1:0]                   pkt_type;
      logic [3:0]                   type_sub;
      logic [`DBG_FLAGS_RSVD_W-1:0] rsvd;
   } flags_ovf_t;

   // the FLAGS flit, decoded through either view
   typedef union packed {
      flags_event_t ev;
      flags_ovf_t   ovf;
   } flags_word_t;

   // one trace event as handed over by a source
   // words[0] is sent first
   typedef struct packed {
      logic [`DBG_NUM_WORDS_W-1:0]                      num_words;
      logic [`DBG_MAX_EVENT_WORDS-1:0][`DBG_WORD_W-1:0] words;
   } event_rec_t;

endpackage

/* hw/event_pkt/event_buffer.sv */
/*
 * single entry trace event buffer
 * word readout by index, overflow drop counter and overflow report
 */
`timescale 1ns/1ps
`include "dbg_defines.svh"

module event_buffer
   import dbg_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        ev_valid,
   input  event_rec_t                  ev,
   output logic                        event_available,
   output logic                        overflow,
   output logic [`DBG_NUM_WORDS_W-1:0] num_words,
   input  logic [`DBG_IDX_W-1:0]       data_req_idx,
   input  logic                        data_req_valid,
   output logic [`DBG_WORD_W-1:0]      data,
   input  logic                        event_consumed
);

   // held item, either an event or an overflow report
   event_rec_t             rec;
   logic                   held;
   logic                   ovf_q;
   // strobes dropped while busy
   logic [`DBG_WORD_W-1:0] drop_cnt;
   logic [`DBG_WORD_W-1:0] drop_nxt;
   logic                   report_load;

   // a strobe while busy is a drop, count saturates
   assign drop_nxt = (held && ev_valid && (drop_cnt != '1)) ? drop_cnt + 1'b1 : drop_cnt;

   // drops pending at consume time turn into an overflow report
   assign report_load = held && event_consumed && (drop_nxt != '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         held     <= 1'b0;
         ovf_q    <= 1'b0;
         drop_cnt <= '0;
      end else begin
         drop_cnt <= drop_nxt;
         if (!held) begin
            if (ev_valid) begin
               held  <= 1'b1;
               ovf_q <= 1'b0;
            end
         end else if (report_load) begin
            // stay busy, count moves into the report
            ovf_q    <= 1'b1;
            drop_cnt <= '0;
         end else if (event_consumed) begin
            held  <= 1'b0;
            ovf_q <= 1'b0;
         end
      end
   end

   // event storage
   always_ff @(posedge clk) begin
      if (!held && ev_valid) begin
         rec <= ev;
      end else if (report_load) begin
         // report is a single word holding the drop count
         rec.num_words <= `DBG_NUM_WORDS_W'(1);
         rec.words[0]  <= drop_nxt;
      end
   end

   assign event_available = held;
   assign overflow        = ovf_q;
   assign num_words       = rec.num_words;
   // combinational word lookup
   assign data            = rec.words[data_req_idx];

   // packetizer only consumes what is held
   a_consume_held: assert property (@(posedge clk) disable iff (rst)
      event_consumed |-> event_available);

   // requested word lies inside the held item
   a_idx_in_range: assert property (@(posedge clk) disable iff (rst)
      data_req_valid |-> ({1'b0, data_req_idx} < num_words));

endmodule

/* hw/event_pkt/event_packetizer.sv */
/*
 * debug event packetizer
 * FSM that sends the held event as one or more debug packets
 * and an overflow report as a single overflow packet
 */
`timescale 1ns/1ps
`include "dbg_defines.svh"

module event_packetizer
   import dbg_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic [15:0]                 src_id,
   input  logic [15:0]                 dest,
   input  logic [`DBG_MOD_SUB_W-1:0]   mod_type_sub,
   input  logic                        event_available,
   input  logic                        overflow,
   input  logic [`DBG_NUM_WORDS_W-1:0] num_words,
   input  logic [`DBG_WORD_W-1:0]      data,
   output logic [`DBG_IDX_W-1:0]       data_req_idx,
   output logic                        data_req_valid,
   output logic                        event_consumed,
   output dii_flit                     debug_out,
   input  logic                        debug_out_ready
);

   localparam int PAYLOAD_LEN = `DBG_MAX_PAYLOAD_LEN;
   localparam int PLD_CNT_W   = $clog2(PAYLOAD_LEN);
   // packets needed for the largest event
   localparam int MAX_PKGS    = (`DBG_MAX_EVENT_WORDS + PAYLOAD_LEN - 1) / PAYLOAD_LEN;
   localparam int PKG_CNT_W   = $clog2(MAX_PKGS);
   localparam int NUM_PKGS_W  = PKG_CNT_W + 1;

   typedef enum logic [2:0] {
      IDLE_DEST,
      SOURCE,
      FLAGS,
      OVERFLOW,
      PAYLOAD
   } state_t;

   state_t                 state;
   state_t                 nxt_state;
   // position inside the event
   logic [`DBG_IDX_W-1:0]  word_cnt;
   logic [`DBG_IDX_W-1:0]  nxt_word_cnt;
   // payload flit inside the current packet
   logic [PLD_CNT_W-1:0]   payload_cnt;
   logic [PLD_CNT_W-1:0]   nxt_payload_cnt;
   // packet inside the current event
   logic [PKG_CNT_W-1:0]   pkg_cnt;
   logic [PKG_CNT_W-1:0]   nxt_pkg_cnt;
   logic [NUM_PKGS_W-1:0]  num_pkgs;
   logic                   last_pkg;
   logic                   word_last;
   logic                   pld_last;
   logic                   accept;
   flags_word_t            flags;

   // ceil(num_words / payload length)
   assign num_pkgs = NUM_PKGS_W'((num_words + `DBG_NUM_WORDS_W'(PAYLOAD_LEN - 1))
                                 / `DBG_NUM_WORDS_W'(PAYLOAD_LEN));
   assign last_pkg  = ({1'b0, pkg_cnt} == (num_pkgs - 1'b1));
   assign word_last = ({1'b0, word_cnt} == (num_words - 1'b1));
   assign pld_last  = (payload_cnt == PLD_CNT_W'(PAYLOAD_LEN - 1));
   assign accept    = debug_out.valid && debug_out_ready;

   assign data_req_idx   = word_cnt;
   assign data_req_valid = (state == PAYLOAD) || (state == OVERFLOW);

   // FLAGS word, written through the view of the packet kind
   always_comb begin
      flags = '0;
      if (overflow) begin
         flags.ovf.pkt_type = `DBG_TYPE_EVENT;
         flags.ovf.type_sub = `DBG_TYPE_SUB_OVERFLOW;
      end else begin
         flags.ev.pkt_type = `DBG_TYPE_EVENT;
         flags.ev.mod_sub  = mod_type_sub;
         // more packets of this event follow
         flags.ev.cont     = !last_pkg;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= IDLE_DEST;
         word_cnt    <= '0;
         payload_cnt <= '0;
         pkg_cnt     <= '0;
      end else begin
         state       <= nxt_state;
         word_cnt    <= nxt_word_cnt;
         payload_cnt <= nxt_payload_cnt;
         pkg_cnt     <= nxt_pkg_cnt;
      end
   end

   always_comb begin
      nxt_state       = state;
      nxt_word_cnt    = word_cnt;
      nxt_payload_cnt = payload_cnt;
      nxt_pkg_cnt     = pkg_cnt;
      event_consumed  = 1'b0;
      debug_out.valid = 1'b0;
      debug_out.last  = 1'b0;
      debug_out.data  = '0;

      case (state)
         IDLE_DEST: begin
            // DEST goes out as soon as something is held
            debug_out.valid = event_available;
            debug_out.data  = dest;
            if (accept) begin
               nxt_state = SOURCE;
            end
         end
         SOURCE: begin
            debug_out.valid = 1'b1;
            debug_out.data  = src_id;
            if (accept) begin
               nxt_state = FLAGS;
            end
         end
         FLAGS: begin
            debug_out.valid = 1'b1;
            debug_out.data  = flags;
            if (accept) begin
               nxt_state = overflow ? OVERFLOW : PAYLOAD;
            end
         end
         OVERFLOW: begin
            // drop count is the only payload flit
            debug_out.valid = 1'b1;
            debug_out.last  = 1'b1;
            debug_out.data  = data;
            if (accept) begin
               event_consumed = 1'b1;
               nxt_state      = IDLE_DEST;
            end
         end
         PAYLOAD: begin
            debug_out.valid = 1'b1;
            debug_out.data  = data;
            // packet ends on the final word or when the packet is full
            debug_out.last  = word_last || pld_last;
            if (accept) begin
               if (word_last) begin
                  event_consumed  = 1'b1;
                  nxt_state       = IDLE_DEST;
                  nxt_word_cnt    = '0;
                  nxt_payload_cnt = '0;
                  nxt_pkg_cnt     = '0;
               end else if (pld_last) begin
                  // event continues in the next packet
                  nxt_state       = IDLE_DEST;
                  nxt_word_cnt    = word_cnt + 1'b1;
                  nxt_payload_cnt = '0;
                  nxt_pkg_cnt     = pkg_cnt + 1'b1;
               end else begin
                  nxt_word_cnt    = word_cnt + 1'b1;
                  nxt_payload_cnt = payload_cnt + 1'b1;
               end
            end
         end
         default: begin
            nxt_state = IDLE_DEST;
         end
      endcase
   end

   // flit held steady under back-pressure, also needs a steady buffer
   a_out_stable: assert property (@(posedge clk) disable iff (rst)
      (debug_out.valid && !debug_out_ready) |=> $stable(debug_out));

endmodule

/* hw/flit_arbiter.sv */
/*
 * two port round-robin flit arbiter
 * grant locked for a whole packet once its first flit is accepted
 */
`timescale 1ns/1ps

module flit_arbiter
   import dbg_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  dii_flit in_a,
   input  dii_flit in_b,
   output logic    in_ready_a,
   output logic    in_ready_b,
   output dii_flit out_flit,
   input  logic    out_ready
);

   // grant 0 selects port a, 1 selects port b
   logic grant;
   logic grant_q;
   logic locked;
   // port that finished the most recent packet
   logic last_served;
   logic accept;

   always_comb begin
      if (locked) begin
         grant = grant_q;
      end else if (in_a.valid && in_b.valid) begin
         // with both waiting the other one gets its turn
         grant = !last_served;
      end else begin
         grant = in_b.valid;
      end
   end

   // output straight from the granted port
   assign out_flit   = grant ? in_b : in_a;
   assign in_ready_a = out_ready && !grant;
   assign in_ready_b = out_ready && grant;
   assign accept     = out_flit.valid && out_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         locked      <= 1'b0;
         grant_q     <= 1'b0;
         // port a first after reset
         last_served <= 1'b1;
      end else if (accept) begin
         grant_q <= grant;
         if (out_flit.last) begin
            locked      <= 1'b0;
            last_served <= grant;
         end else begin
            locked <= 1'b1;
         end
      end
   end

   // the locked port keeps its flit valid until the packet ends
   a_locked_valid: assert property (@(posedge clk) disable iff (rst)
      locked |-> out_flit.valid);

endmodule

/* hw/trace_subsystem_top.sv */
/*
 * trace subsystem top level
 * two event buffer and packetizer pairs sharing one debug link
 */
`timescale 1ns/1ps
`include "dbg_defines.svh"

module trace_subsystem_top
   import dbg_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      ev_valid_a,
   input  event_rec_t                ev_a,
   input  logic                      ev_valid_b,
   input  event_rec_t                ev_b,
   input  logic [15:0]               src_id_a,
   input  logic [15:0]               src_id_b,
   input  logic [15:0]               dest,
   input  logic [`DBG_MOD_SUB_W-1:0] type_sub_a,
   input  logic [`DBG_MOD_SUB_W-1:0] type_sub_b,
   output dii_flit                   debug_out,
   input  logic                      debug_out_ready
);

   // buffer to packetizer, source a
   logic                        avail_a;
   logic                        ovf_a;
   logic [`DBG_NUM_WORDS_W-1:0] nwords_a;
   logic [`DBG_IDX_W-1:0]       idx_a;
   logic                        req_a;
   logic [`DBG_WORD_W-1:0]      data_a;
   logic                        consumed_a;
   // buffer to packetizer, source b
   logic                        avail_b;
   logic                        ovf_b;
   logic [`DBG_NUM_WORDS_W-1:0] nwords_b;
   logic [`DBG_IDX_W-1:0]       idx_b;
   logic                        req_b;
   logic [`DBG_WORD_W-1:0]      data_b;
   logic                        consumed_b;
   // packetizer to arbiter
   dii_flit                     flit_a;
   dii_flit                     flit_b;
   logic                        ready_a;
   logic                        ready_b;

   event_buffer i_event_buffer_a (
      .clk(clk), .rst(rst), .ev_valid(ev_valid_a), .ev(ev_a),
      .event_available(avail_a), .overflow(ovf_a), .num_words(nwords_a),
      .data_req_idx(idx_a), .data_req_valid(req_a), .data(data_a),
      .event_consumed(consumed_a)
   );

   event_packetizer i_event_packetizer_a (
      .clk(clk), .rst(rst), .src_id(src_id_a), .dest(dest), .mod_type_sub(type_sub_a),
      .event_available(avail_a), .overflow(ovf_a), .num_words(nwords_a), .data(data_a),
      .data_req_idx(idx_a), .data_req_valid(req_a), .event_consumed(consumed_a),
      .debug_out(flit_a), .debug_out_ready(ready_a)
   );

   event_buffer i_event_buffer_b (
      .clk(clk), .rst(rst), .ev_valid(ev_valid_b), .ev(ev_b),
      .event_available(avail_b), .overflow(ovf_b), .num_words(nwords_b),
      .data_req_idx(idx_b), .data_req_valid(req_b), .data(data_b),
      .event_consumed(consumed_b)
   );

   event_packetizer i_event_packetizer_b (
      .clk(clk), .rst(rst), .src_id(src_id_b), .dest(dest), .mod_type_sub(type_sub_b),
      .event_available(avail_b), .overflow(ovf_b), .num_words(nwords_b), .data(data_b),
      .data_req_idx(idx_b), .data_req_valid(req_b), .event_consumed(consumed_b),
      .debug_out(flit_b), .debug_out_ready(ready_b)
   );

   flit_arbiter i_flit_arbiter (
      .clk(clk), .rst(rst),
      .in_a(flit_a), .in_b(flit_b), .in_ready_a(ready_a), .in_ready_b(ready_b),
      .out_flit(debug_out), .out_ready(debug_out_ready)
   );

endmodule

/* tests/tb_trace_subsystem.sv */
/*
 * directed testbench for the trace subsystem
 * clock and reset, output flit collector, expected packet model,
 * compare tasks and one task per tested behavior
 */
`timescale 1ns/1ps
`include "dbg_defines.svh"

module tb_trace_subsystem
   import dbg_pkg::*;
();

   localparam logic [15:0]               DEST_ID     = 16'h00f0;
   localparam logic [15:0]               SRC_ID_A    = 16'h0011;
   localparam logic [15:0]               SRC_ID_B    = 16'h0022;
   localparam logic [`DBG_MOD_SUB_W-1:0] SUB_A       = 3'd2;
   localparam logic [`DBG_MOD_SUB_W-1:0] SUB_B       = 3'd6;
   localparam int                        DRAIN_LIMIT = 600;

   logic       clk;
   logic       rst;
   logic       ev_valid_a;
   event_rec_t ev_a;
   logic       ev_valid_b;
   event_rec_t ev_b;
   dii_flit    debug_out;
   logic       debug_out_ready = 1'b1;
   // random ready gaps on the output link
   logic       bp_on = 1'b0;

   integer seed = 32;
   int     mismatches;
   int     other_errors;
   int     timeouts;

   // expected flits per source
   dii_flit exp_a[$];
   dii_flit exp_b[$];
   // kind bit per expected packet is 1 for an overflow packet
   logic    kind_a[$];
   logic    kind_b[$];
   // packet being collected
   dii_flit pkt[$];
   // source of every finished packet with 0 for a
   int      src_log[$];

   trace_subsystem_top i_trace_subsystem_top (
      .clk(clk), .rst(rst),
      .ev_valid_a(ev_valid_a), .ev_a(ev_a), .ev_valid_b(ev_valid_b), .ev_b(ev_b),
      .src_id_a(SRC_ID_A), .src_id_b(SRC_ID_B), .dest(DEST_ID),
      .type_sub_a(SUB_A), .type_sub_b(SUB_B),
      .debug_out(debug_out), .debug_out_ready(debug_out_ready)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

   always @(negedge clk) begin
      if (bp_on) begin
         // roughly one cycle in four without ready
         debug_out_ready = (($random(seed) & 3) != 0);
      end else begin
         debug_out_ready = 1'b1;
      end
   end

   // collector takes a flit in a cycle with valid and ready
   always @(posedge clk) begin
      if (!rst && debug_out.valid && debug_out_ready) begin
         pkt.push_back(debug_out);
         if (debug_out.last) begin
            score_packet();
            pkt.delete();
         end
      end
   end

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      mismatches++;
      $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
   endtask

   // whole flit with valid, last and data
   task automatic check_flit(input string name, input dii_flit got, input dii_flit exp);
      if (got !== exp) begin
         report_mismatch(name, 32'(got), 32'(exp));
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_mismatch(name, 32'(got), 32'(exp));
      end
   endtask

   // FLAGS fields read through the view that the packet kind implies
   task automatic check_flags(input flags_word_t got, input flags_word_t exp,
                              input logic is_ovf);
      if (is_ovf) begin
         if (got.ovf.pkt_type !== exp.ovf.pkt_type) begin
            report_mismatch("flags.pkt_type", 32'(got.ovf.pkt_type), 32'(exp.ovf.pkt_type));
         end
         if (got.ovf.type_sub !== exp.ovf.type_sub) begin
            report_mismatch("flags.type_sub", 32'(got.ovf.type_sub), 32'(exp.ovf.type_sub));
         end
         if (got.ovf.rsvd !== exp.ovf.rsvd) begin
            report_mismatch("flags.rsvd", 32'(got.ovf.rsvd), 32'(exp.ovf.rsvd));
         end
      end else begin
         if (got.ev.pkt_type !== exp.ev.pkt_type) begin
            report_mismatch("flags.pkt_type", 32'(got.ev.pkt_type), 32'(exp.ev.pkt_type));
         end
         if (got.ev.mod_sub !== exp.ev.mod_sub) begin
            report_mismatch("flags.mod_sub", 32'(got.ev.mod_sub), 32'(exp.ev.mod_sub));
         end
         if (got.ev.cont !== exp.ev.cont) begin
            report_mismatch("flags.cont", 32'(got.ev.cont), 32'(exp.ev.cont));
         end
         if (got.ev.rsvd !== exp.ev.rsvd) begin
            report_mismatch("flags.rsvd", 32'(got.ev.rsvd), 32'(exp.ev.rsvd));
         end
      end
   endtask

   task automatic push_flit(input int src, input logic last, input logic [15:0] data);
      dii_flit f;
      f.valid = 1'b1;
      f.last  = last;
      f.data  = data;
      if (src == 0) begin
         exp_a.push_back(f);
      end else begin
         exp_b.push_back(f);
      end
   endtask

   // every packet repeats DEST, SRC and FLAGS
   task automatic add_header(input int src, input flags_word_t flags, input logic is_ovf);
      push_flit(src, 1'b0, DEST_ID);
      push_flit(src, 1'b0, (src == 0) ? SRC_ID_A : SRC_ID_B);
      push_flit(src, 1'b0, flags);
      if (src == 0) begin
         kind_a.push_back(is_ovf);
      end else begin
         kind_b.push_back(is_ovf);
      end
   endtask

   // event split into packets of at most max length minus header payload words
   task automatic expect_event(input int src, input event_rec_t rec);
      flags_word_t flags;
      int          n;
      int          sent;
      int          chunk;
      int          k;
      n    = int'(rec.num_words);
      sent = 0;
      while (sent < n) begin
         chunk = (n - sent > `DBG_MAX_PAYLOAD_LEN) ? `DBG_MAX_PAYLOAD_LEN : n - sent;
         flags             = '0;
         flags.ev.pkt_type = `DBG_TYPE_EVENT;
         flags.ev.mod_sub  = (src == 0) ? SUB_A : SUB_B;
         // continue bit on every packet but the final one
         flags.ev.cont     = (sent + chunk < n);
         add_header(src, flags, 1'b0);
         for (k = 0; k < chunk; k++) begin
            push_flit(src, k == chunk - 1, rec.words[sent + k]);
         end
         sent = sent + chunk;
      end
   endtask

   task automatic expect_overflow(input int src, input logic [15:0] count);
      flags_word_t flags;
      flags              = '0;
      flags.ovf.pkt_type = `DBG_TYPE_EVENT;
      flags.ovf.type_sub = `DBG_TYPE_SUB_OVERFLOW;
      add_header(src, flags, 1'b1);
      // drop count is the single payload flit
      push_flit(src, 1'b1, count);
   endtask

   // finished packet is matched to its source by the SRC flit
   task automatic score_packet();
      dii_flit exp;
      logic    is_ovf;
      int      src;
      if (pkt.size() < 4) begin
         other_errors++;
         $display("packet of only %0d flits ended at %0t ns", pkt.size(), $time);
         return;
      end
      if (pkt[1].data == SRC_ID_A) begin
         src = 0;
      end else if (pkt[1].data == SRC_ID_B) begin
         src = 1;
      end else begin
         other_errors++;
         $display("packet with unknown source id %0h at %0t ns", pkt[1].data, $time);
         return;
      end
      if ((src == 0 && kind_a.size() == 0) || (src == 1 && kind_b.size() == 0)) begin
         other_errors++;
         $display("packet from source %0d arrived with none expected at %0t ns", src, $time);
         return;
      end
      is_ovf = (src == 0) ? kind_a.pop_front() : kind_b.pop_front();
      src_log.push_back(src);
      foreach (pkt[i]) begin
         if ((src == 0 && exp_a.size() == 0) || (src == 1 && exp_b.size() == 0)) begin
            other_errors++;
            $display("source %0d sent more flits than expected at %0t ns", src, $time);
            return;
         end
         exp = (src == 0) ? exp_a.pop_front() : exp_b.pop_front();
         check_flit($sformatf("debug_out flit %0d of source %0d", i, src), pkt[i], exp);
         if (i == 2) begin
            check_flags(pkt[i].data, exp.data, is_ovf);
         end
      end
   endtask

   function automatic logic all_received();
      return (exp_a.size() == 0) && (exp_b.size() == 0) && (pkt.size() == 0);
   endfunction

   task automatic end_run();
      $display("errors: %0d mismatches, %0d other failures, %0d timeouts",
               mismatches, other_errors, timeouts);
      if (mismatches + other_errors + timeouts == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (!all_received() && n < DRAIN_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!all_received()) begin
         timeouts++;
         $display("timeout after %0d cycles with %0d flits of a and %0d of b still missing",
                  n, exp_a.size(), exp_b.size());
      end
   endtask

   // words are base plus index, or random
   task automatic make_event(input int n, input int base, input logic rnd,
                             output event_rec_t rec);
      int i;
      rec           = '0;
      rec.num_words = `DBG_NUM_WORDS_W'(n);
      for (i = 0; i < n; i++) begin
         if (rnd) begin
            rec.words[i] = 16'($random(seed));
         end else begin
            rec.words[i] = 16'(base + i);
         end
      end
   endtask

   // single cycle strobe on either or both ports from a falling edge
   task automatic strobe(input logic va, input event_rec_t a, input logic vb,
                         input event_rec_t b);
      ev_valid_a = va;
      ev_a       = a;
      ev_valid_b = vb;
      ev_b       = b;
      @(negedge clk);
      ev_valid_a = 1'b0;
      ev_valid_b = 1'b0;
   endtask

   task automatic idle_after_reset();
      int i;
      for (i = 0; i < 10; i++) begin
         compare_bit("debug_out.valid", debug_out.valid, 1'b0);
         @(negedge clk);
      end
   endtask

   task automatic single_packet_event();
      event_rec_t rec;
      make_event(3, 'h1000, 1'b0, rec);
      expect_event(0, rec);
      strobe(1'b1, rec, 1'b0, '0);
      wait_drained();
   endtask

   // 5, 5 and 2 payload words
   task automatic split_event();
      event_rec_t rec;
      make_event(12, 'h2000, 1'b0, rec);
      expect_event(0, rec);
      strobe(1'b1, rec, 1'b0, '0);
      wait_drained();
   endtask

   // first strobe is taken and the next three are dropped and reported
   task automatic overflow_report();
      event_rec_t recs[4];
      int         i;
      for (i = 0; i < 4; i++) begin
         make_event(2 + i, 'h3000 + 'h100 * i, 1'b0, recs[i]);
      end
      expect_event(1, recs[0]);
      expect_overflow(1, 16'd3);
      for (i = 0; i < 4; i++) begin
         ev_valid_b = 1'b1;
         ev_b       = recs[i];
         @(negedge clk);
      end
      ev_valid_b = 1'b0;
      wait_drained();
   endtask

   // both ports busy for three packets each
   task automatic arbitration();
      event_rec_t rec_a;
      event_rec_t rec_b;
      int         first;
      int         i;
      make_event(12, 'h4000, 1'b0, rec_a);
      make_event(12, 'h5000, 1'b0, rec_b);
      first = src_log.size();
      expect_event(0, rec_a);
      expect_event(1, rec_b);
      strobe(1'b1, rec_a, 1'b1, rec_b);
      wait_drained();
      if (src_log.size() - first != 6) begin
         other_errors++;
         $display("arbitration test saw %0d packets instead of 6", src_log.size() - first);
      end
      for (i = first + 1; i < src_log.size(); i++) begin
         if (src_log[i] == src_log[i - 1]) begin
            other_errors++;
            $display("source %0d got two packets in a row while both were busy", src_log[i]);
         end
      end
   endtask

   task automatic back_pressure();
      event_rec_t rec_a;
      event_rec_t rec_b;
      make_event(7, 0, 1'b1, rec_a);
      make_event(4, 0, 1'b1, rec_b);
      expect_event(0, rec_a);
      expect_event(1, rec_b);
      bp_on = 1'b1;
      strobe(1'b1, rec_a, 1'b0, '0);
      @(negedge clk);
      strobe(1'b0, '0, 1'b1, rec_b);
      wait_drained();
      bp_on = 1'b0;
   endtask

   initial begin
      rst        = 1'b1;
      ev_valid_a = 1'b0;
      ev_a       = '0;
      ev_valid_b = 1'b0;
      ev_b       = '0;
      repeat (5) @(negedge clk);
      rst = 1'b0;
      idle_after_reset();
      single_packet_event();
      split_event();
      overflow_report();
      arbitration();
      back_pressure();
      end_run();
   end

endmodule

/* all.f */
+incdir+common
common/dbg_pkg.sv
hw/event_pkt/event_buffer.sv
hw/event_pkt/event_packetizer.sv
hw/flit_arbiter.sv
hw/trace_subsystem_top.sv
tests/tb_trace_subsystem.sv

/* Makefile */
# Verilator build and run of the trace subsystem testbench
VERILATOR ?= verilator
TOP       ?= tb_trace_subsystem
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Result: FAILED
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build, run, then search the log for the fail message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
